/* sim.f */
+incdir+include
design/lycan_pkg.sv
design/sync_fifo.sv
design/ft601_controller.sv
design/periph_interconnect.sv
design/lycan_periph.sv
design/lycan_top.sv
tb/lycan_assertions.sv
tb/lycan_tb.sv

/* Makefile */
TOP := lycan_tb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f sim.f

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -Mdir obj_dir -f sim.f
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG) || ! grep -q '\*\*\* PASSED \*\*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

/* tb/lycan_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lycan_config.svh"

module lycan_tb;

  localparam int NUM_ROWS       = 4;
  localparam int NUM_PAIRS      = 24;
  localparam int TIMEOUT_CYCLES = 2000;
  localparam int QUIET_CYCLES   = 64;

  // one stimulus row, words come from pairs[first +: count]
  typedef struct packed {
    logic [7:0] first;
    logic [7:0] count;
    logic       tx_gaps;
    logic       rx_gaps;
  } row_t;

  logic                 clk = 1'b0;
  logic                 arst_n = 1'b0;
  logic                 usb_rx_empty = 1'b1;
  logic                 usb_tx_full = 1'b0;
  lycan_pkg::usb_word_t usb_data_in = '0;
  lycan_pkg::usb_word_t usb_data_out;
  logic                 usb_data_oe;
  logic                 usb_rden_l;
  logic                 usb_wren_l;
  logic                 usb_outen_l;

  row_t                   rows [NUM_ROWS];
  string                  row_name [NUM_ROWS];
  lycan_pkg::usb_packet_t pairs [NUM_PAIRS];

  // host send queue and outstanding expected replies
  lycan_pkg::usb_packet_t send_q [$];
  lycan_pkg::usb_packet_t exp_q [$];
  lycan_pkg::payload_t    ctr_count = '0;

  logic tx_gaps = 1'b0;
  logic rx_gaps = 1'b0;
  int   checks = 0;
  int   errors = 0;
  int   test_errs = 0;
  int   tests_run = 0;
  int   tests_failed = 0;

  always #2 clk = ~clk;

  lycan_top dut_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .usb_rx_empty (usb_rx_empty),
    .usb_tx_full  (usb_tx_full),
    .usb_data_in  (usb_data_in),
    .usb_data_out (usb_data_out),
    .usb_data_oe  (usb_data_oe),
    .usb_rden_l   (usb_rden_l),
    .usb_wren_l   (usb_wren_l),
    .usb_outen_l  (usb_outen_l)
  );

  // reply the host should see for one sent word
  function automatic lycan_pkg::usb_packet_t expected_reply(input lycan_pkg::usb_packet_t pkt);
    lycan_pkg::usb_packet_t rsp;
    rsp = pkt;
    // address 0 answers with its running request count
    if (pkt.addr == '0) begin
      ctr_count   = ctr_count + 1'b1;
      rsp.payload = ctr_count;
    end
    return rsp;
  endfunction

  // match against the oldest outstanding reply for the same address
  task automatic check_reply(input lycan_pkg::usb_word_t word);
    lycan_pkg::usb_packet_t got;
    int                     idx;
    got = word;
    idx = -1;
    checks++;
    for (int i = 0; i < exp_q.size(); i++) begin
      if (idx < 0 && exp_q[i].addr == got.addr) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("error @%0t: unexpected reply %h for address %0d", $time, word, got.addr);
      errors++;
      test_errs++;
    end else begin
      if (got != exp_q[idx]) begin
        $display("error @%0t: address %0d got %h expected %h", $time, got.addr, word,
                 exp_q[idx]);
        errors++;
        test_errs++;
      end
      exp_q.delete(idx);
    end
  endtask

  // host model, all decisions use values from before the edge
  always @(posedge clk) begin
    if (!arst_n) begin
      usb_rx_empty <= 1'b1;
      usb_tx_full  <= 1'b0;
    end else begin
      // word taken by the controller
      if (!usb_rden_l && !usb_rx_empty) begin
        void'(send_q.pop_front());
      end
      // reply handed over
      if (!usb_wren_l && !usb_tx_full) begin
        check_reply(usb_data_out);
      end
      if (send_q.size() > 0 && !(rx_gaps && ($urandom % 4 == 0))) begin
        usb_rx_empty <= 1'b0;
        usb_data_in  <= send_q[0];
      end else begin
        usb_rx_empty <= 1'b1;
      end
      usb_tx_full <= tx_gaps && ($urandom % 3 == 0);
    end
  end

  initial begin
    int cycles;
    int first;
    int count;
    void'($urandom(62403));

    // word pool for the table rows
    pairs[0] = {2'd2, 30'($urandom)};
    for (int k = 1; k < 4; k++) begin
      pairs[k] = {2'd0, 30'($urandom)};
    end
    // first four cover every address, rest random
    for (int k = 4; k < NUM_PAIRS; k++) begin
      pairs[k].addr    = (k < 8) ? lycan_pkg::periph_addr_t'(k - 4)
                                 : lycan_pkg::periph_addr_t'($urandom % `LYCAN_NUM_PERIPH);
      pairs[k].payload = 30'($urandom);
    end

    rows[0] = '{first: 8'd0, count: 8'd1, tx_gaps: 1'b0, rx_gaps: 1'b0};
    rows[1] = '{first: 8'd1, count: 8'd3, tx_gaps: 1'b0, rx_gaps: 1'b0};
    rows[2] = '{first: 8'd4, count: 8'd20, tx_gaps: 1'b0, rx_gaps: 1'b0};
    rows[3] = '{first: 8'd4, count: 8'd20, tx_gaps: 1'b1, rx_gaps: 1'b1};
    row_name[0] = "single_loopback";
    row_name[1] = "counter_three";
    row_name[2] = "mixed_burst";
    row_name[3] = "mixed_burst_gaps";

    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    // idle pins straight after reset
    @(posedge clk);
    tests_run++;
    if (!usb_rden_l || !usb_wren_l || !usb_outen_l || usb_data_oe) begin
      $display("error @%0t: strobes not idle after reset", $time);
      errors++;
      tests_failed++;
      $display("test 0 reset_idle: bad");
    end else begin
      $display("test 0 reset_idle: ok");
    end

    for (int t = 0; t < NUM_ROWS; t++) begin
      test_errs = 0;
      first     = int'(rows[t].first);
      count     = int'(rows[t].count);
      // load the row between host model edges
      @(negedge clk);
      tx_gaps = rows[t].tx_gaps;
      rx_gaps = rows[t].rx_gaps;
      for (int k = 0; k < count; k++) begin
        send_q.push_back(pairs[first + k]);
        exp_q.push_back(expected_reply(pairs[first + k]));
      end
      // drain until every reply is back
      cycles = 0;
      while (exp_q.size() > 0 && cycles < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycles++;
      end
      if (exp_q.size() > 0) begin
        $display("test %0d %s: timed out, %0d replies went missing", t + 1, row_name[t],
                 exp_q.size());
        exp_q.delete();
        test_errs++;
        errors++;
      end
      // any extra reply showing up now is a duplicate of this row
      repeat (QUIET_CYCLES) @(posedge clk);
      tests_run++;
      if (test_errs != 0) begin
        tests_failed++;
      end
      $display("test %0d %s: %0d words, %s", t + 1, row_name[t], count,
               (test_errs == 0) ? "ok" : "bad");
    end

    $display("tests %0d, failed %0d, replies checked %0d, errors %0d", tests_run,
             tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb/lycan_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module lycan_assertions (
  input wire logic clk,
  input wire logic arst_n,
  input wire logic usb_rden_l,
  input wire logic usb_wren_l,
  input wire logic usb_outen_l,
  input wire logic usb_data_oe,
  input wire logic out_pop,
  input wire logic out_empty
);

  // FT601 bus is half duplex, never read and write at once
  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (!arst_n)
    !(!usb_rden_l && !usb_wren_l))
    else $error("read and write strobes low in the same cycle");

  // host may only drive data while we have output enable low
  a_outen_during_read: assert property (@(posedge clk) disable iff (!arst_n)
    !usb_rden_l |-> !usb_outen_l)
    else $error("read strobe low without output enable");

  // output enable leads the read strobe by one turnaround clk
  a_outen_turnaround: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(usb_rden_l) |-> $past(!usb_outen_l))
    else $error("read strobe fell without a turnaround cycle");

  // pin driver follows the write strobe exactly
  a_oe_matches_wren: assert property (@(posedge clk) disable iff (!arst_n)
    usb_data_oe == !usb_wren_l)
    else $error("data output enable out of step with write strobe");

  // outbound FIFO safety
  a_no_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
    out_pop |-> !out_empty)
    else $error("outbound FIFO popped while empty");

endmodule

// attached to every lycan_top instance
bind lycan_top lycan_assertions lycan_assert_i (
  .clk         (clk),
  .arst_n      (arst_n),
  .usb_rden_l  (usb_rden_l),
  .usb_wren_l  (usb_wren_l),
  .usb_outen_l (usb_outen_l),
  .usb_data_oe (usb_data_oe),
  .out_pop     (out_pop),
  .out_empty   (out_empty)
);

`default_nettype wire

/* design/lycan_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lycan_config.svh"

module lycan_top (
  input  logic                 clk,
  input  logic                 arst_n,
  // FT601 flags, 0 means data available / space available
  input  logic                 usb_rx_empty,
  input  logic                 usb_tx_full,
  // data pins split into in, out and enable
  input  lycan_pkg::usb_word_t usb_data_in,
  output lycan_pkg::usb_word_t usb_data_out,
  output logic                 usb_data_oe,
  // FT601 strobes, active low
  output logic                 usb_rden_l,
  output logic                 usb_wren_l,
  output logic                 usb_outen_l
);

  localparam int NUM = `LYCAN_NUM_PERIPH;

  // inbound FIFO
  logic                   in_push;
  logic                   in_pop;
  logic                   in_empty;
  logic                   in_almost_full;
  lycan_pkg::usb_packet_t in_head;

  // outbound FIFO
  logic                   out_push;
  logic                   out_pop;
  logic                   out_empty;
  logic                   out_full;
  lycan_pkg::usb_word_t   out_din;

  // peripheral bus
  logic [NUM-1:0]                   req;
  lycan_pkg::payload_t              req_payload;
  logic [NUM-1:0]                   periph_full;
  lycan_pkg::usb_word_t [NUM-1:0]   rsp;
  logic [NUM-1:0]                   rsp_valid;
  logic [NUM-1:0]                   rsp_pop;

  ft601_controller ft601_ctrl (
    .clk            (clk),
    .arst_n         (arst_n),
    .usb_rx_empty   (usb_rx_empty),
    .usb_tx_full    (usb_tx_full),
    .usb_rden_l     (usb_rden_l),
    .usb_wren_l     (usb_wren_l),
    .usb_outen_l    (usb_outen_l),
    .usb_data_oe    (usb_data_oe),
    .in_push        (in_push),
    .in_almost_full (in_almost_full),
    .out_empty      (out_empty),
    .out_pop        (out_pop)
  );

  // host words, head read as a packet by the interconnect
  sync_fifo #(
    .DEPTH (`LYCAN_FIFO_DEPTH)
  ) in_fifo (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (in_push),
    .din         (usb_data_in),
    .pop         (in_pop),
    .dout        (in_head),
    .empty       (in_empty),
    .full        (),
    .almost_full (in_almost_full)
  );

  // replies, head drives the data pins directly
  sync_fifo #(
    .DEPTH (`LYCAN_FIFO_DEPTH)
  ) out_fifo (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (out_push),
    .din         (out_din),
    .pop         (out_pop),
    .dout        (usb_data_out),
    .empty       (out_empty),
    .full        (out_full),
    .almost_full ()
  );

  periph_interconnect periph_ic (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_head     (in_head),
    .in_empty    (in_empty),
    .in_pop      (in_pop),
    .req         (req),
    .req_payload (req_payload),
    .periph_full (periph_full),
    .rsp         (rsp),
    .rsp_valid   (rsp_valid),
    .rsp_pop     (rsp_pop),
    .out_full    (out_full),
    .out_push    (out_push),
    .out_din     (out_din)
  );

  // peripheral 0 counts, the others echo
  for (genvar i = 0; i < NUM; i++) begin : gen_periph
    lycan_periph #(
      .ADDR (lycan_pkg::periph_addr_t'(i)),
      .KIND ((i == 0) ? lycan_pkg::PERIPH_COUNTER : lycan_pkg::PERIPH_LOOPBACK)
    ) periph (
      .clk         (clk),
      .arst_n      (arst_n),
      .req         (req[i]),
      .req_payload (req_payload),
      .rsp         (rsp[i]),
      .rsp_valid   (rsp_valid[i]),
      .rsp_pop     (rsp_pop[i]),
      .full        (periph_full[i])
    );
  end

endmodule

`default_nettype wire

/* design/lycan_periph.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lycan_config.svh"

module lycan_periph #(
  parameter lycan_pkg::periph_addr_t ADDR = '0,
  parameter lycan_pkg::periph_kind_t KIND = lycan_pkg::PERIPH_LOOPBACK
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 req,
  input  lycan_pkg::payload_t  req_payload,
  output lycan_pkg::usb_word_t rsp,
  output logic                 rsp_valid,
  input  logic                 rsp_pop,
  output logic                 full
);

  // reply queue kept shallow so back-pressure shows up early
  localparam int QUEUE_DEPTH = `LYCAN_FIFO_DEPTH / 2;

  lycan_pkg::usb_packet_t reply;
  logic                   queue_empty;

  // every reply carries our own address
  assign reply.addr = ADDR;

  if (KIND == lycan_pkg::PERIPH_COUNTER) begin : gen_counter
    lycan_pkg::payload_t req_count;

    // running number of requests seen, wraps at payload width
    always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
        req_count <= '0;
      end else if (req) begin
        req_count <= req_count + 1'b1;
      end
    end

    // count including the current request
    assign reply.payload = req_count + 1'b1;
  end else begin : gen_loopback
    // echo the payload back
    assign reply.payload = req_payload;
  end

  // reply lands in the queue at the end of the req cycle
  // and is visible one clk later
  sync_fifo #(
    .DEPTH (QUEUE_DEPTH)
  ) rsp_queue (
    .clk         (clk),
    .arst_n      (arst_n),
    .push        (req),
    .din         (reply),
    .pop         (rsp_pop),
    .dout        (rsp),
    .empty       (queue_empty),
    .full        (full),
    .almost_full ()
  );

  assign rsp_valid = ~queue_empty;

endmodule

`default_nettype wire

/* design/periph_interconnect.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lycan_config.svh"

module periph_interconnect (
  input  logic                                           clk,
  input  logic                                           arst_n,
  // head of the inbound FIFO
  input  lycan_pkg::usb_packet_t                         in_head,
  input  logic                                           in_empty,
  output logic                                           in_pop,
  // request side toward the peripherals
  output logic [`LYCAN_NUM_PERIPH-1:0]                   req,
  output lycan_pkg::payload_t                            req_payload,
  input  logic [`LYCAN_NUM_PERIPH-1:0]                   periph_full,
  // reply side from the peripherals
  input  lycan_pkg::usb_word_t [`LYCAN_NUM_PERIPH-1:0]   rsp,
  input  logic [`LYCAN_NUM_PERIPH-1:0]                   rsp_valid,
  output logic [`LYCAN_NUM_PERIPH-1:0]                   rsp_pop,
  // outbound FIFO
  input  logic                                           out_full,
  output logic                                           out_push,
  output lycan_pkg::usb_word_t                           out_din
);

  localparam int NUM = `LYCAN_NUM_PERIPH;

  lycan_pkg::periph_addr_t last_gnt;
  lycan_pkg::periph_addr_t gnt_idx;
  logic                    gnt_found;

  // decode, head word goes out only if its target has room
  // a blocked head holds up everything behind it
  always_comb begin
    req    = '0;
    in_pop = 1'b0;
    if (!in_empty && !periph_full[in_head.addr]) begin
      req[in_head.addr] = 1'b1;
      in_pop            = 1'b1;
    end
  end

  assign req_payload = in_head.payload;

  // round robin search, starting one past the last winner
  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = last_gnt;
    for (int i = 1; i <= NUM; i++) begin
      if (!gnt_found && rsp_valid[(int'(last_gnt) + i) % NUM]) begin
        gnt_found = 1'b1;
        gnt_idx   = lycan_pkg::periph_addr_t'((int'(last_gnt) + i) % NUM);
      end
    end
  end

  // full outbound FIFO stalls every grant
  assign out_push = gnt_found && !out_full;
  assign out_din  = rsp[gnt_idx];

  always_comb begin
    rsp_pop          = '0;
    rsp_pop[gnt_idx] = out_push;
  end

  // after reset the search begins at peripheral 0
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      last_gnt <= lycan_pkg::periph_addr_t'(NUM - 1);
    end else if (out_push) begin
      last_gnt <= gnt_idx;
    end
  end

endmodule

`default_nettype wire

/* design/ft601_controller.sv */
`timescale 1ns/1ps
`default_nettype none

module ft601_controller (
  input  logic clk,
  input  logic arst_n,
  // host side levels, both active low in meaning
  input  logic usb_rx_empty,
  input  logic usb_tx_full,
  // FT601 strobes
  output logic usb_rden_l,
  output logic usb_wren_l,
  output logic usb_outen_l,
  output logic usb_data_oe,
  // inbound FIFO
  output logic in_push,
  input  logic in_almost_full,
  // outbound FIFO
  input  logic out_empty,
  output logic out_pop
);

  lycan_pkg::ft_state_t state;
  lycan_pkg::ft_state_t state_nxt;
  logic                 wr_active;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= lycan_pkg::FT_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      lycan_pkg::FT_IDLE: begin
        // pending replies win when starting from idle
        if (!out_empty) begin
          state_nxt = lycan_pkg::FT_WRITE;
        end else if (!usb_rx_empty && !in_almost_full) begin
          state_nxt = lycan_pkg::FT_READ_OE;
        end
      end
      lycan_pkg::FT_READ_OE: begin
        // one cycle of bus turnaround, host starts driving
        state_nxt = lycan_pkg::FT_READ;
      end
      lycan_pkg::FT_READ: begin
        // host ran dry or inbound side is nearly full
        if (usb_rx_empty || in_almost_full) begin
          state_nxt = lycan_pkg::FT_IDLE;
        end
      end
      lycan_pkg::FT_WRITE: begin
        // tx_full only stalls, leave once nothing is left
        if (out_empty) begin
          state_nxt = lycan_pkg::FT_IDLE;
        end
      end
      default: begin
        state_nxt = lycan_pkg::FT_IDLE;
      end
    endcase
  end

  // write strobe only while a valid word sits at the head
  assign wr_active = (state == lycan_pkg::FT_WRITE) && !out_empty;

  assign usb_rden_l  = ~(state == lycan_pkg::FT_READ);
  // outen stays low through the whole read burst
  assign usb_outen_l = ~((state == lycan_pkg::FT_READ_OE) || (state == lycan_pkg::FT_READ));
  assign usb_wren_l  = ~wr_active;
  // we own the data pins exactly while writing
  assign usb_data_oe = wr_active;

  // word taken from the host
  assign in_push = (state == lycan_pkg::FT_READ) && !usb_rx_empty;
  // word handed to the host
  assign out_pop = wr_active && !usb_tx_full;

endmodule

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lycan_config.svh"

module sync_fifo #(
  parameter int DEPTH = `LYCAN_FIFO_DEPTH
) (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                push,
  input  lycan_pkg::usb_word_t din,
  input  logic                pop,
  output lycan_pkg::usb_word_t dout,
  output logic                empty,
  output logic                full,
  output logic                almost_full
);

  // pointers wrap naturally since DEPTH is a power of two
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  // count needs one extra state for "full"
  localparam int CNT_W = $clog2(DEPTH + 1);

  lycan_pkg::usb_word_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // drop push on full and pop on empty
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // storage
  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy only moves when exactly one side fires
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // show-ahead, head word always on dout
  assign dout  = mem[rd_ptr];
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  // two spare slots left for reads already under way
  assign almost_full = (count >= CNT_W'(DEPTH - 2));

endmodule

`default_nettype wire

/* design/lycan_pkg.sv */
`default_nettype none

`include "lycan_config.svh"

package lycan_pkg;

  // raw word as seen on the FT601 data pins
  typedef logic [`LYCAN_DATA_W-1:0] usb_word_t;

  // peripheral select field
  typedef logic [`LYCAN_ADDR_W-1:0] periph_addr_t;

  // whatever is left below the address
  typedef logic [`LYCAN_DATA_W-`LYCAN_ADDR_W-1:0] payload_t;

  // address sits in the upper bits, same size as usb_word_t
  typedef struct packed {
    periph_addr_t addr;
    payload_t     payload;
  } usb_packet_t;

  // peripheral behaviour
  typedef enum logic [0:0] {
    PERIPH_LOOPBACK,
    PERIPH_COUNTER
  } periph_kind_t;

  // FT601 controller states
  typedef enum logic [1:0] {
    FT_IDLE,
    FT_READ_OE,
    FT_READ,
    FT_WRITE
  } ft_state_t;

endpackage

`default_nettype wire

/* include/lycan_config.svh */
`ifndef LYCAN_CONFIG_SVH
`define LYCAN_CONFIG_SVH

// width of one FT601 bus word
`define LYCAN_DATA_W 32

// peripherals hanging off the interconnect
`define LYCAN_NUM_PERIPH 4

// address field at the top of each host word
// must cover LYCAN_NUM_PERIPH
`define LYCAN_ADDR_W 2

// default FIFO depth, power of two
`define LYCAN_FIFO_DEPTH 8

`endif
